//--- sim.f
hdl/div_pkg.sv
hdl/div_operand_prep.sv
hdl/div_iter_counter.sv
hdl/div_control_fsm.sv
hdl/div_radix2_core.sv
hdl/div_result_fix.sv
hdl/div_unit.sv
verif/div_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the divide unit testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/10ps --top-module div_unit_tb -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vdiv_unit_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Testbench passed$"; then
    exit 0
fi
exit 1

//--- verif/div_unit_tb.sv
/*
 * testbench for the divide unit
 * seeded random DIV, DIVU, REM and REMU requests checked against a division model,
 * done latency, hold-until-ack and stray-start checks, error counts and a cycle limit
 */
`timescale 1ns/10ps

module div_unit_tb;

    localparam int NUM_REQS = 400;
    localparam int CYCLE_LIMIT = NUM_REQS * 40 + 200;  // a request takes at most 38 cycles
    localparam int LAT_NORMAL = 33;  // load edge plus 32 step edges
    localparam int LAT_EARLY = 1;    // load edge only
    localparam div_pkg::word_t MOST_NEG = {1'b1, {(div_pkg::XLEN-1){1'b0}}};

    logic clk;
    logic rst;
    logic start;
    logic ack;
    div_pkg::div_req_t req;
    div_pkg::word_t result;
    logic done;
    logic busy;

    int value_errs = 0;      // wrong result words
    int timing_errs = 0;     // done rising on the wrong cycle
    int handshake_errs = 0;  // wrong done or busy levels
    int cycles = 0;

    div_unit dut_i (
        .clk(clk),
        .rst(rst),
        .start(start),
        .ack(ack),
        .req(req),
        .result(result),
        .done(done),
        .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // RISC-V M extension rules, division by zero and signed overflow handled first
    function automatic div_pkg::word_t model_result(input div_pkg::div_req_t r);
        div_pkg::word_t q;
        div_pkg::word_t m;
        if (r.rs2 == '0) begin
            q = '1;
            m = r.rs1;
        end else if (r.is_signed && r.rs1 == MOST_NEG && r.rs2 == '1) begin
            q = MOST_NEG;
            m = '0;
        end else if (r.is_signed) begin
            q = $signed(r.rs1) / $signed(r.rs2);  // truncates toward zero
            m = $signed(r.rs1) % $signed(r.rs2);  // sign follows the dividend
        end else begin
            q = r.rs1 / r.rs2;
            m = r.rs1 % r.rs2;
        end
        return r.want_rem ? m : q;
    endfunction

    // a divisor magnitude above the dividend magnitude skips all the steps
    function automatic int expected_latency(input div_pkg::div_req_t r);
        div_pkg::word_t a;
        div_pkg::word_t b;
        a = (r.is_signed && r.rs1[div_pkg::XLEN-1]) ? -r.rs1 : r.rs1;
        b = (r.is_signed && r.rs2[div_pkg::XLEN-1]) ? -r.rs2 : r.rs2;
        return (b > a) ? LAT_EARLY : LAT_NORMAL;
    endfunction

    // operands lean toward the corner values of the division rules
    function automatic div_pkg::word_t pick_operand();
        int unsigned kind;
        kind = $urandom_range(0, 9);
        case (kind)
            0: return '0;
            1: return 32'd1;
            2: return '1;  // minus one when signed
            3: return MOST_NEG;
            4, 5: return div_pkg::word_t'($urandom_range(2, 15));
            default: return $urandom;
        endcase
    endfunction

    function automatic div_pkg::div_req_t random_request();
        div_pkg::div_req_t r;
        int unsigned mode;
        mode = $urandom_range(0, 9);
        r.rs1 = pick_operand();
        r.rs2 = pick_operand();
        r.is_signed = $urandom_range(0, 1) == 1;
        r.want_rem = $urandom_range(0, 1) == 1;
        if (mode == 0) begin
            r.rs1 = MOST_NEG;  // signed overflow case
            r.rs2 = '1;
            r.is_signed = 1'b1;
        end else if (mode == 1) begin
            r.rs2 = '0;
        end else if (mode == 2) begin
            // small dividend against a large positive divisor takes the early exit
            r.rs1 = div_pkg::word_t'($urandom_range(0, 255));
            r.rs2 = ($urandom >> 2) | 32'h0001_0000;
        end
        return r;
    endfunction

    task automatic check_word(input string name, input div_pkg::word_t exp,
                              input div_pkg::word_t got);
        if (got !== exp) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
            value_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, got);
            handshake_errs++;
        end
    endtask

    initial begin
        div_pkg::div_req_t cur;
        div_pkg::word_t exp;
        int exp_lat;
        int lat;
        int stray_at;
        int ack_delay;
        void'($urandom(32'hbc4e));
        rst = 1'b1;
        start = 1'b0;
        ack = 1'b0;
        req = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_bit("done", 1'b0, done);  // nothing started yet
            check_bit("busy", 1'b0, busy);
        end
        for (int n = 0; n < NUM_REQS; n++) begin
            cur = random_request();
            exp = model_result(cur);
            exp_lat = expected_latency(cur);
            stray_at = 0;
            if (exp_lat == LAT_NORMAL && $urandom_range(0, 3) == 0) begin
                stray_at = int'($urandom_range(2, 30));
            end
            req = cur;
            start = 1'b1;
            lat = 0;
            do begin
                @(negedge clk);
                lat++;
                start = 1'b0;
                check_bit("busy", 1'b1, busy);
                if (lat == stray_at) begin
                    // start with fresh operands in the middle of the run, must be dropped
                    start = 1'b1;
                    req = random_request();
                end
            end while (!done);
            if (lat != exp_lat) begin
                $display("FAIL t=%0t done latency expected %0d got %0d", $time, exp_lat, lat);
                timing_errs++;
            end
            check_word("result", exp, result);
            ack_delay = int'($urandom_range(0, 3));
            repeat (ack_delay) begin
                @(negedge clk);
                start = $urandom_range(0, 1) == 1;  // ignored while done is held
                req = random_request();
                check_bit("done", 1'b1, done);
                check_word("result", exp, result);
            end
            start = 1'b0;
            ack = 1'b1;
            @(negedge clk);
            ack = 1'b0;
            check_bit("busy", 1'b0, busy);  // idle right after the ack edge
            check_bit("done", 1'b0, done);
            @(negedge clk);
            // a dropped start must not have left a second divide behind
            check_bit("done", 1'b0, done);
            check_bit("busy", 1'b0, busy);
        end
        $display("errors: value %0d, timing %0d, handshake %0d",
                 value_errs, timing_errs, handshake_errs);
        if (value_errs + timing_errs + handshake_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // stops a run where done never comes
    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("errors: value %0d, timing %0d, handshake %0d",
                 value_errs, timing_errs, handshake_errs);
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- hdl/div_unit.sv
/*
 * 32-bit integer divide unit, top level
 * operand prep, controller, iteration counter, datapath and sign fix-up
 */
`timescale 1ns/10ps

module div_unit (
    input logic clk,
    input logic rst,
    input logic start,
    input logic ack,
    input div_pkg::div_req_t req,
    output div_pkg::word_t result,
    output logic done,
    output logic busy
);

    div_pkg::div_init_t init;  // core start values from the current request
    div_pkg::div_sign_t sign;  // sign flags from the current request
    logic early;               // divisor magnitude above dividend magnitude
    logic load;
    logic step;
    logic last;
    div_pkg::word_t quo;
    div_pkg::word_t rem;

    div_operand_prep u_prep (
        .req(req),
        .init(init),
        .sign(sign),
        .early(early)
    );

    div_control_fsm u_fsm (
        .clk(clk),
        .rst(rst),
        .start(start),
        .ack(ack),
        .early(early),
        .last(last),
        .load(load),
        .step(step),
        .done(done),
        .busy(busy)
    );

    div_iter_counter u_counter (
        .clk(clk),
        .rst(rst),
        .load(load),
        .step(step),
        .last(last)
    );

    div_radix2_core u_core (
        .clk(clk),
        .load(load),
        .step(step),
        .init(init),
        .quo(quo),
        .rem(rem)
    );

    div_result_fix u_fix (
        .clk(clk),
        .load(load),
        .sign(sign),
        .quo(quo),
        .rem(rem),
        .result(result)
    );

endmodule

//--- hdl/div_result_fix.sv
/*
 * result sign fix-up
 * captures the sign flags at load and returns the signed quotient or remainder
 */
`timescale 1ns/10ps

module div_result_fix (
    input logic clk,
    input logic load,
    input div_pkg::div_sign_t sign,
    input div_pkg::word_t quo,
    input div_pkg::word_t rem,
    output div_pkg::word_t result
);

    div_pkg::div_sign_t sign_r;  // flags of the divide in flight
    div_pkg::word_t mag;
    logic neg;

    // req may change after start, so the flags are kept with the operation
    always_ff @(posedge clk) begin
        if (load) begin
            sign_r <= sign;
        end
    end

    always_comb begin
        mag = sign_r.want_rem ? rem : quo;
        neg = sign_r.want_rem ? sign_r.neg_r : sign_r.neg_q;
        result = neg ? -mag : mag;  // two's complement negation of the magnitude
    end

endmodule

//--- hdl/div_radix2_core.sv
/*
 * radix-2 restoring divider datapath
 * partial remainder, quotient and divisor registers, one trial subtraction per step
 */
`timescale 1ns/10ps

module div_radix2_core (
    input logic clk,
    input logic load,
    input logic step,
    input div_pkg::div_init_t init,
    output div_pkg::word_t quo,
    output div_pkg::word_t rem
);

    div_pkg::pr_t pr;          // partial remainder, low bit is the next dividend bit
    div_pkg::pr_t trial;       // partial remainder minus divisor
    div_pkg::word_t q;         // dividend bits shift out the top, quotient bits in below
    div_pkg::word_t divisor;
    logic borrow;

    // zero-extended divisor so the subtraction has room for the borrow
    assign trial = pr - {1'b0, divisor};
    assign borrow = trial[div_pkg::XLEN];  // set when the divisor did not fit

    always_ff @(posedge clk) begin
        if (load) begin
            pr <= init.pr;
            q <= init.q;
            divisor <= init.divisor;
        end else if (step) begin
            // restoring step, keep the old value on a borrow and the difference otherwise
            // either way the next dividend bit comes in from the top of q
            if (borrow) begin
                pr <= {pr[div_pkg::XLEN-1:0], q[div_pkg::XLEN-1]};
            end else begin
                pr <= {trial[div_pkg::XLEN-1:0], q[div_pkg::XLEN-1]};
            end
            q <= {q[div_pkg::XLEN-2:0], ~borrow};  // quotient bit is the inverted borrow
        end
    end

    assign quo = q;
    assign rem = pr[div_pkg::XLEN:1];  // low bit of pr is a dividend bit, not remainder

    // the controller must never step the datapath in the cycle it loads it
    a_no_step_on_load: assert property (@(posedge clk) load |-> !step);

endmodule

//--- hdl/div_control_fsm.sv
/*
 * divide controller FSM
 * idle, run and done states, load and step strobes, done held until ack
 */
`timescale 1ns/10ps

module div_control_fsm (
    input logic clk,
    input logic rst,
    input logic start,
    input logic ack,
    input logic early,
    input logic last,
    output logic load,
    output logic step,
    output logic done,
    output logic busy
);

    div_pkg::div_state_t state;
    div_pkg::div_state_t next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= div_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        load = 1'b0;
        step = 1'b0;
        unique case (state)
            div_pkg::IDLE: begin
                // start is only taken here and dropped at any other time
                if (start) begin
                    load = 1'b1;
                    next_state = early ? div_pkg::DONE : div_pkg::RUN;
                end
            end
            div_pkg::RUN: begin
                step = 1'b1;  // one restoring step every cycle
                if (last) next_state = div_pkg::DONE;
            end
            div_pkg::DONE: begin
                if (ack) next_state = div_pkg::IDLE;  // result is held until then
            end
            default: next_state = div_pkg::IDLE;
        endcase
    end

    assign done = state == div_pkg::DONE;
    assign busy = state != div_pkg::IDLE;

    // the counter may only reach its final count while the core is being stepped
    a_last_in_run: assert property (@(posedge clk) disable iff (rst)
        last |-> state == div_pkg::RUN);

    // done may only appear after the final step or an early-terminated load
    a_done_entry: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> $past(step && last) || $past(load && early));

endmodule

//--- hdl/div_iter_counter.sv
/*
 * iteration counter for the shift-subtract loop, flags the final step
 */
`timescale 1ns/10ps

module div_iter_counter (
    input logic clk,
    input logic rst,
    input logic load,
    input logic step,
    output logic last
);

    div_pkg::step_t count;

    always_ff @(posedge clk) begin
        if (rst || load) begin
            count <= '0;  // a new divide always starts counting from zero
        end else if (step) begin
            count <= count + 1'b1;
        end
    end

    // high during the final step, the FSM leaves RUN on it
    assign last = count == div_pkg::step_t'(div_pkg::STEPS - 1);

    // the controller must stop stepping once the final step has been taken
    a_count_range: assert property (@(posedge clk) disable iff (rst)
        step |-> count <= div_pkg::step_t'(div_pkg::STEPS - 1));

endmodule

//--- hdl/div_operand_prep.sv
/*
 * operand preparation for the divider
 * magnitude conversion, early-termination check, initial core state and sign flags
 */
`timescale 1ns/10ps

module div_operand_prep (
    input div_pkg::div_req_t req,
    output div_pkg::div_init_t init,
    output div_pkg::div_sign_t sign,
    output logic early
);

    logic rs1_neg;
    logic rs2_neg;
    div_pkg::word_t rs1_mag;
    div_pkg::word_t rs2_mag;

    // an operand only counts as negative for the signed variants
    assign rs1_neg = req.is_signed & req.rs1[div_pkg::XLEN-1];
    assign rs2_neg = req.is_signed & req.rs2[div_pkg::XLEN-1];

    // the most negative value maps onto itself, which reads correctly as unsigned
    assign rs1_mag = rs1_neg ? -req.rs1 : req.rs1;
    assign rs2_mag = rs2_neg ? -req.rs2 : req.rs2;

    // quotient must be zero when the divisor is bigger, so no steps are needed
    // a zero divisor never triggers this and runs the full sequence
    assign early = rs2_mag > rs1_mag;

    always_comb begin
        init.divisor = rs2_mag;
        if (early) begin
            init.pr = {rs1_mag, 1'b0};  // remainder field already holds the dividend
            init.q = '0;
        end else begin
            // top dividend bit sits in the low bit of pr, the rest waits in q
            init.pr = {{div_pkg::XLEN{1'b0}}, rs1_mag[div_pkg::XLEN-1]};
            init.q = {rs1_mag[div_pkg::XLEN-2:0], 1'b0};
        end
    end

    // a zero divisor keeps the all-ones quotient positive for DIV as well
    assign sign.neg_q = (rs1_neg ^ rs2_neg) & (|req.rs2);
    assign sign.neg_r = rs1_neg;  // remainder takes the sign of the dividend
    assign sign.want_rem = req.want_rem;

endmodule

//--- hdl/div_pkg.sv
/*
 * shared definitions for the integer divide unit
 * word width and step count, vector types for operands and partial remainder,
 * request, load-state and sign fix-up structs, and the control states
 */
package div_pkg;

    // operand width and number of restoring iterations, one per quotient bit
    localparam int XLEN = 32;
    localparam int STEPS = XLEN;

    typedef logic [XLEN-1:0] word_t;  // one operand or result word
    typedef logic [XLEN:0] pr_t;      // partial remainder, top bit shows the borrow
    typedef logic [5:0] step_t;       // iteration count, holds values up to STEPS

    // one divide request as presented at the top level
    typedef struct packed {
        word_t rs1;       // dividend
        word_t rs2;       // divisor
        logic is_signed;  // DIV or REM when set, DIVU or REMU when clear
        logic want_rem;   // return the remainder instead of the quotient
    } div_req_t;

    // values loaded into the shift-subtract core at the start of a divide
    typedef struct packed {
        pr_t pr;         // initial partial remainder
        word_t q;        // dividend bits still to be shifted in, then quotient
        word_t divisor;  // divisor magnitude
    } div_init_t;

    // flags for turning the magnitude result back into a signed one
    typedef struct packed {
        logic neg_q;     // quotient gets negated
        logic neg_r;     // remainder gets negated, follows the dividend sign
        logic want_rem;  // selects the remainder as the result
    } div_sign_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } div_state_t;

endpackage
